//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0] reg_ix_t;

  // major opcodes the core executes, anything else is dropped at decode
  typedef enum logic [6:0] {
    OPC_OP    = 7'b0110011,
    OPC_OPIMM = 7'b0010011,
    OPC_LUI   = 7'b0110111
  } opcode_e;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra, srai
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASSB, // operand two straight through, lui
    ALU_MUL
  } alu_op_e;

  // which station takes the instruction
  typedef enum logic {
    UNIT_ALU,
    UNIT_MUL
  } unit_e;

endpackage

`default_nettype wire

//--- src/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int ROB_SIZE = 8;
  localparam int RS_DEPTH = 3;
  localparam int IQ_CREDITS = 4; // queue depth and the source's starting credits
  // product reaches the bus this many cycles after grant
  localparam int MUL_STAGES = 3;

  typedef logic [$clog2(ROB_SIZE)-1:0] rob_tag_t;
  typedef logic [$clog2(ROB_SIZE+1)-1:0] rob_cnt_t;
  typedef logic [$clog2(IQ_CREDITS+1)-1:0] credit_cnt_t;

endpackage

`default_nettype wire

//--- src/inst_queue_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue_decode import isa_pkg::*, core_pkg::*; (
  input wire clk_100mhz,
  input wire sys_rst,
  input wire i_inst_valid,
  input wire inst_t i_inst,
  input wire i_pop,
  output logic o_credit,
  output logic o_head_valid,
  output logic o_supported,
  output unit_e o_unit,
  output alu_op_e o_op,
  output reg_ix_t o_rd,
  output reg_ix_t o_rs1,
  output reg_ix_t o_rs2,
  output logic o_uses_imm,
  output word_t o_imm
);
  localparam int PTR_W = $clog2(IQ_CREDITS);

  inst_t queue_mem [IQ_CREDITS];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  credit_cnt_t count;
  logic pop;
  inst_t head;
  logic [6:0] funct7;
  logic [2:0] funct3;

  assign o_head_valid = (count != '0);
  assign pop = i_pop && o_head_valid;
  assign o_credit = pop; // credit returns as the entry leaves
  assign head = queue_mem[rd_ptr];
  assign funct7 = head[31:25];
  assign funct3 = head[14:12];

  // source only sends while holding credit, so a push always has room
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (i_inst_valid) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + credit_cnt_t'(i_inst_valid) - credit_cnt_t'(pop);
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_inst_valid) queue_mem[wr_ptr] <= i_inst;
  end

  always_comb begin
    o_supported = 1'b1;
    o_unit = UNIT_ALU;
    o_op = ALU_ADD;
    o_uses_imm = 1'b0;
    o_imm = {{20{head[31]}}, head[31:20]}; // i-type
    o_rd = head[11:7];
    o_rs1 = head[19:15];
    o_rs2 = head[24:20];
    case (head[6:0])
      OPC_OP: begin
        case ({funct7, funct3})
          {F7_BASE, 3'b000}: o_op = ALU_ADD;
          {F7_ALT, 3'b000}: o_op = ALU_SUB;
          {F7_BASE, 3'b001}: o_op = ALU_SLL;
          {F7_BASE, 3'b010}: o_op = ALU_SLT;
          {F7_BASE, 3'b011}: o_op = ALU_SLTU;
          {F7_BASE, 3'b100}: o_op = ALU_XOR;
          {F7_BASE, 3'b101}: o_op = ALU_SRL;
          {F7_ALT, 3'b101}: o_op = ALU_SRA;
          {F7_BASE, 3'b110}: o_op = ALU_OR;
          {F7_BASE, 3'b111}: o_op = ALU_AND;
          {F7_MULDIV, 3'b000}: begin
            o_op = ALU_MUL;
            o_unit = UNIT_MUL;
          end
          default: o_supported = 1'b0; // div, rem, mulh*
        endcase
      end
      OPC_OPIMM: begin
        o_uses_imm = 1'b1;
        case (funct3)
          3'b000: o_op = ALU_ADD;
          3'b010: o_op = ALU_SLT;
          3'b011: o_op = ALU_SLTU;
          3'b100: o_op = ALU_XOR;
          3'b110: o_op = ALU_OR;
          3'b111: o_op = ALU_AND;
          3'b001: begin
            o_op = ALU_SLL;
            o_supported = (funct7 == F7_BASE);
          end
          default: begin
            // shamt sits in imm[4:0], funct7 picks srli or srai
            o_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            o_supported = (funct7 == F7_BASE) || (funct7 == F7_ALT);
          end
        endcase
      end
      OPC_LUI: begin
        o_op = ALU_PASSB;
        o_uses_imm = 1'b1;
        o_imm = {head[31:12], 12'b0};
        o_rs1 = '0; // no real source, avoid a false wait
      end
      default: o_supported = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/rename_issue.sv
`timescale 1ns/1ps
`default_nettype none

module rename_issue import isa_pkg::*, core_pkg::*; (
  input wire clk_100mhz,
  input wire sys_rst,
  input wire i_head_valid,
  input wire i_supported,
  input wire unit_e i_unit,
  input wire alu_op_e i_op,
  input wire reg_ix_t i_rd,
  input wire reg_ix_t i_rs1,
  input wire reg_ix_t i_rs2,
  input wire i_uses_imm,
  input wire word_t i_imm,
  input wire i_rob_full,
  input wire i_rs_alu_free,
  input wire i_rs_mul_free,
  input wire rob_tag_t i_alloc_tag,
  input wire i_fwd1_ready,
  input wire word_t i_fwd1_value,
  input wire i_fwd2_ready,
  input wire word_t i_fwd2_value,
  input wire i_cdb_valid,
  input wire rob_tag_t i_cdb_tag,
  input wire word_t i_cdb_value,
  input wire i_commit_valid,
  input wire reg_ix_t i_commit_rd,
  input wire word_t i_commit_value,
  input wire rob_tag_t i_commit_tag,
  output logic o_pop,
  output logic o_rob_alloc,
  output reg_ix_t o_alloc_rd,
  output logic o_rs_alu_load,
  output logic o_rs_mul_load,
  output alu_op_e o_op,
  output rob_tag_t o_tag,
  output rob_tag_t o_qj_tag,
  output logic o_qj_wait,
  output word_t o_vj,
  output rob_tag_t o_qk_tag,
  output logic o_qk_wait,
  output word_t o_vk,
  output rob_tag_t o_fwd1_tag,
  output rob_tag_t o_fwd2_tag
);
  word_t regs [32];
  logic [31:0] busy; // register waits on a rob entry
  rob_tag_t map_tag [32];
  logic station_free;
  logic issue;

  assign station_free = (i_unit == UNIT_MUL) ? i_rs_mul_free : i_rs_alu_free;
  assign issue = i_head_valid && i_supported && !i_rob_full && station_free;
  assign o_pop = issue || (i_head_valid && !i_supported); // unsupported just drains
  assign o_rob_alloc = issue;
  assign o_rs_alu_load = issue && (i_unit == UNIT_ALU);
  assign o_rs_mul_load = issue && (i_unit == UNIT_MUL);
  assign o_alloc_rd = i_rd;
  assign o_op = i_op;
  assign o_tag = i_alloc_tag;
  assign o_fwd1_tag = map_tag[i_rs1];
  assign o_fwd2_tag = map_tag[i_rs2];
  assign o_qj_tag = o_fwd1_tag;
  assign o_qk_tag = o_fwd2_tag;

  // source order: register file, finished rob entry, this cycle's bus, else wait
  always_comb begin
    o_qj_wait = 1'b0;
    if (!busy[i_rs1]) begin
      o_vj = (i_rs1 == '0) ? '0 : regs[i_rs1];
    end else if (i_fwd1_ready) begin
      o_vj = i_fwd1_value;
    end else if (i_cdb_valid && i_cdb_tag == o_qj_tag) begin
      o_vj = i_cdb_value;
    end else begin
      o_vj = '0;
      o_qj_wait = 1'b1;
    end
  end

  always_comb begin
    o_qk_wait = 1'b0;
    if (i_uses_imm) begin
      o_vk = i_imm;
    end else if (!busy[i_rs2]) begin
      o_vk = (i_rs2 == '0) ? '0 : regs[i_rs2];
    end else if (i_fwd2_ready) begin
      o_vk = i_fwd2_value;
    end else if (i_cdb_valid && i_cdb_tag == o_qk_tag) begin
      o_vk = i_cdb_value;
    end else begin
      o_vk = '0;
      o_qk_wait = 1'b1;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
      for (int r = 0; r < 32; r++) regs[r] <= '0;
    end else begin
      if (i_commit_valid && i_commit_rd != '0) begin
        regs[i_commit_rd] <= i_commit_value;
        // a younger writer keeps the register renamed
        if (map_tag[i_commit_rd] == i_commit_tag) busy[i_commit_rd] <= 1'b0;
      end
      if (issue && i_rd != '0) busy[i_rd] <= 1'b1; // x0 never renamed
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (issue && i_rd != '0) map_tag[i_rd] <= i_alloc_tag;
  end

endmodule

`default_nettype wire

//--- src/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station import isa_pkg::*, core_pkg::*; #(
  parameter int DEPTH = RS_DEPTH
) (
  input wire clk_100mhz,
  input wire sys_rst,
  input wire i_load,
  input wire alu_op_e i_op,
  input wire rob_tag_t i_tag,
  input wire rob_tag_t i_qj_tag,
  input wire i_qj_wait,
  input wire word_t i_vj,
  input wire rob_tag_t i_qk_tag,
  input wire i_qk_wait,
  input wire word_t i_vk,
  input wire i_cdb_valid,
  input wire rob_tag_t i_cdb_tag,
  input wire word_t i_cdb_value,
  input wire i_grant,
  output logic o_free,
  output logic o_dispatch_valid,
  output alu_op_e o_dispatch_op,
  output word_t o_dispatch_a,
  output word_t o_dispatch_b,
  output rob_tag_t o_dispatch_tag
);
  // slot 0 is the oldest, live entries stay packed toward it
  logic [DEPTH-1:0] valid, n_valid;
  logic [DEPTH-1:0] qj_wait, n_qj_wait, qk_wait, n_qk_wait;
  alu_op_e op [DEPTH], n_op [DEPTH];
  rob_tag_t tag [DEPTH], n_tag [DEPTH];
  rob_tag_t qj_tag [DEPTH], n_qj_tag [DEPTH];
  rob_tag_t qk_tag [DEPTH], n_qk_tag [DEPTH];
  word_t vj [DEPTH], n_vj [DEPTH];
  word_t vk [DEPTH], n_vk [DEPTH];
  logic [DEPTH-1:0] ready;
  logic take;
  int sel;

  assign ready = valid & ~qj_wait & ~qk_wait;
  assign o_free = !valid[DEPTH-1];
  assign take = i_grant && o_dispatch_valid;

  always_comb begin
    sel = 0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (ready[i]) sel = i; // lowest ready slot wins
    end
  end

  assign o_dispatch_valid = |ready;
  assign o_dispatch_op = op[sel];
  assign o_dispatch_a = vj[sel];
  assign o_dispatch_b = vk[sel];
  assign o_dispatch_tag = tag[sel];

  always_comb begin
    int src;
    int s;
    int slot;
    slot = $countones(valid) - int'(take);
    for (int i = 0; i < DEPTH; i++) begin
      src = (take && i >= sel) ? i + 1 : i; // close the gap behind a dispatch
      s = (src < DEPTH) ? src : DEPTH - 1;
      n_valid[i] = (src < DEPTH) && valid[s];
      n_op[i] = op[s];
      n_tag[i] = tag[s];
      n_qj_tag[i] = qj_tag[s];
      n_qk_tag[i] = qk_tag[s];
      // bus snoop
      n_qj_wait[i] = qj_wait[s] && !(i_cdb_valid && qj_tag[s] == i_cdb_tag);
      n_qk_wait[i] = qk_wait[s] && !(i_cdb_valid && qk_tag[s] == i_cdb_tag);
      n_vj[i] = (qj_wait[s] && !n_qj_wait[i]) ? i_cdb_value : vj[s];
      n_vk[i] = (qk_wait[s] && !n_qk_wait[i]) ? i_cdb_value : vk[s];
    end
    // new entry lands behind the survivors
    if (i_load && slot < DEPTH) begin
      n_valid[slot] = 1'b1;
      n_op[slot] = i_op;
      n_tag[slot] = i_tag;
      n_qj_tag[slot] = i_qj_tag;
      n_qk_tag[slot] = i_qk_tag;
      n_qj_wait[slot] = i_qj_wait;
      n_qk_wait[slot] = i_qk_wait;
      n_vj[slot] = i_vj;
      n_vk[slot] = i_vk;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) valid <= '0;
    else valid <= n_valid;
  end

  always_ff @(posedge clk_100mhz) begin
    qj_wait <= n_qj_wait;
    qk_wait <= n_qk_wait;
    op <= n_op;
    tag <= n_tag;
    qj_tag <= n_qj_tag;
    qk_tag <= n_qk_tag;
    vj <= n_vj;
    vk <= n_vk;
  end

endmodule

`default_nettype wire

//--- src/exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster import isa_pkg::*, core_pkg::*; (
  input wire clk_100mhz,
  input wire sys_rst,
  input wire i_alu_valid,
  input wire alu_op_e i_alu_op,
  input wire word_t i_alu_a,
  input wire word_t i_alu_b,
  input wire rob_tag_t i_alu_tag,
  input wire i_mul_valid,
  input wire word_t i_mul_a,
  input wire word_t i_mul_b,
  input wire rob_tag_t i_mul_tag,
  output logic o_alu_grant,
  output logic o_mul_grant,
  output logic o_cdb_valid,
  output rob_tag_t o_cdb_tag,
  output word_t o_cdb_value
);
  logic alu_v;
  rob_tag_t alu_tag;
  word_t alu_res, alu_next;
  logic [MUL_STAGES-1:0] mul_v;
  rob_tag_t mul_tag [MUL_STAGES];
  word_t mul_prod [MUL_STAGES];

  // bus slot after next belongs to the product now in the second-last stage
  assign o_mul_grant = i_mul_valid;
  assign o_alu_grant = i_alu_valid && !mul_v[MUL_STAGES-2];

  always_comb begin
    case (i_alu_op)
      ALU_ADD: alu_next = i_alu_a + i_alu_b;
      ALU_SUB: alu_next = i_alu_a - i_alu_b;
      ALU_AND: alu_next = i_alu_a & i_alu_b;
      ALU_OR: alu_next = i_alu_a | i_alu_b;
      ALU_XOR: alu_next = i_alu_a ^ i_alu_b;
      ALU_SLL: alu_next = i_alu_a << i_alu_b[4:0];
      ALU_SRL: alu_next = i_alu_a >> i_alu_b[4:0];
      ALU_SRA: alu_next = $signed(i_alu_a) >>> i_alu_b[4:0];
      ALU_SLT: alu_next = {31'b0, $signed(i_alu_a) < $signed(i_alu_b)};
      ALU_SLTU: alu_next = {31'b0, i_alu_a < i_alu_b};
      default: alu_next = i_alu_b; // passb for lui
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      alu_v <= 1'b0;
      mul_v <= '0;
    end else begin
      alu_v <= o_alu_grant;
      mul_v <= {mul_v[MUL_STAGES-2:0], o_mul_grant};
    end
  end

  // stages after the first give retiming room for the multiplier
  always_ff @(posedge clk_100mhz) begin
    alu_tag <= i_alu_tag;
    alu_res <= alu_next;
    mul_tag[0] <= i_mul_tag;
    mul_prod[0] <= i_mul_a * i_mul_b; // low 32 bits only
    for (int s = 1; s < MUL_STAGES; s++) begin
      mul_tag[s] <= mul_tag[s-1];
      mul_prod[s] <= mul_prod[s-1];
    end
  end

  // at most one of the two is valid by construction
  assign o_cdb_valid = mul_v[MUL_STAGES-1] || alu_v;
  assign o_cdb_tag = mul_v[MUL_STAGES-1] ? mul_tag[MUL_STAGES-1] : alu_tag;
  assign o_cdb_value = mul_v[MUL_STAGES-1] ? mul_prod[MUL_STAGES-1] : alu_res;

endmodule

`default_nettype wire

//--- src/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import isa_pkg::*, core_pkg::*; (
  input wire clk_100mhz,
  input wire sys_rst,
  input wire i_alloc,
  input wire reg_ix_t i_alloc_rd,
  input wire rob_tag_t i_fwd1_tag,
  input wire rob_tag_t i_fwd2_tag,
  input wire i_cdb_valid,
  input wire rob_tag_t i_cdb_tag,
  input wire word_t i_cdb_value,
  output rob_tag_t o_alloc_tag,
  output logic o_full,
  output logic o_fwd1_ready,
  output word_t o_fwd1_value,
  output logic o_fwd2_ready,
  output word_t o_fwd2_value,
  output logic o_commit_valid,
  output reg_ix_t o_commit_rd,
  output word_t o_commit_value,
  output rob_tag_t o_commit_tag
);
  rob_tag_t head, tail; // wrap naturally, ROB_SIZE is a power of two
  rob_cnt_t count;
  logic [ROB_SIZE-1:0] done;
  reg_ix_t dest_rd [ROB_SIZE];
  word_t result [ROB_SIZE];

  assign o_alloc_tag = tail;
  assign o_full = (count == rob_cnt_t'(ROB_SIZE));

  // rename only asks about tags it still maps, so those entries are live
  assign o_fwd1_ready = done[i_fwd1_tag];
  assign o_fwd1_value = result[i_fwd1_tag];
  assign o_fwd2_ready = done[i_fwd2_tag];
  assign o_fwd2_value = result[i_fwd2_tag];

  assign o_commit_valid = (count != '0) && done[head];
  assign o_commit_rd = dest_rd[head];
  assign o_commit_value = result[head];
  assign o_commit_tag = head;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      done <= '0;
    end else begin
      if (i_cdb_valid) done[i_cdb_tag] <= 1'b1;
      if (i_alloc) begin
        done[tail] <= 1'b0;
        tail <= tail + 1'b1;
      end
      if (o_commit_valid) head <= head + 1'b1;
      count <= count + rob_cnt_t'(i_alloc) - rob_cnt_t'(o_commit_valid);
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_alloc) dest_rd[tail] <= i_alloc_rd;
    if (i_cdb_valid) result[i_cdb_tag] <= i_cdb_value;
  end

endmodule

`default_nettype wire

//--- src/ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top import isa_pkg::*, core_pkg::*; (
  input wire clk_100mhz,
  input wire sys_rst,
  input wire i_inst_valid,
  input wire inst_t i_inst,
  output logic o_credit,
  output logic o_commit_valid,
  output reg_ix_t o_commit_rd,
  output word_t o_commit_value
);
  // decoded queue head
  logic head_valid, supported, uses_imm, pop;
  unit_e dec_unit;
  alu_op_e dec_op;
  reg_ix_t dec_rd, dec_rs1, dec_rs2;
  word_t dec_imm;

  // issue
  logic rob_alloc, rs_alu_load, rs_mul_load, qj_wait, qk_wait;
  reg_ix_t alloc_rd;
  alu_op_e iss_op;
  rob_tag_t iss_tag, qj_tag, qk_tag, fwd1_tag, fwd2_tag;
  word_t vj, vk;

  // reorder buffer
  logic rob_full, fwd1_ready, fwd2_ready;
  rob_tag_t alloc_tag, commit_tag;
  word_t fwd1_value, fwd2_value;

  // stations, units and the bus
  logic alu_free, mul_free, alu_disp_valid, mul_disp_valid, alu_grant, mul_grant;
  alu_op_e alu_disp_op;
  word_t alu_a, alu_b, mul_a, mul_b;
  rob_tag_t alu_disp_tag, mul_disp_tag;
  logic cdb_valid;
  rob_tag_t cdb_tag;
  word_t cdb_value;

  inst_queue_decode u_iq (
    .clk_100mhz, .sys_rst, .i_inst_valid, .i_inst, .i_pop(pop),
    .o_credit, .o_head_valid(head_valid), .o_supported(supported), .o_unit(dec_unit),
    .o_op(dec_op), .o_rd(dec_rd), .o_rs1(dec_rs1), .o_rs2(dec_rs2),
    .o_uses_imm(uses_imm), .o_imm(dec_imm)
  );

  rename_issue u_rename (
    .clk_100mhz, .sys_rst, .i_head_valid(head_valid), .i_supported(supported),
    .i_unit(dec_unit), .i_op(dec_op), .i_rd(dec_rd), .i_rs1(dec_rs1), .i_rs2(dec_rs2),
    .i_uses_imm(uses_imm), .i_imm(dec_imm), .i_rob_full(rob_full),
    .i_rs_alu_free(alu_free), .i_rs_mul_free(mul_free), .i_alloc_tag(alloc_tag),
    .i_fwd1_ready(fwd1_ready), .i_fwd1_value(fwd1_value),
    .i_fwd2_ready(fwd2_ready), .i_fwd2_value(fwd2_value),
    .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_value(cdb_value),
    .i_commit_valid(o_commit_valid), .i_commit_rd(o_commit_rd),
    .i_commit_value(o_commit_value), .i_commit_tag(commit_tag),
    .o_pop(pop), .o_rob_alloc(rob_alloc), .o_alloc_rd(alloc_rd),
    .o_rs_alu_load(rs_alu_load), .o_rs_mul_load(rs_mul_load), .o_op(iss_op),
    .o_tag(iss_tag), .o_qj_tag(qj_tag), .o_qj_wait(qj_wait), .o_vj(vj),
    .o_qk_tag(qk_tag), .o_qk_wait(qk_wait), .o_vk(vk),
    .o_fwd1_tag(fwd1_tag), .o_fwd2_tag(fwd2_tag)
  );

  reservation_station rs_alu (
    .clk_100mhz, .sys_rst, .i_load(rs_alu_load), .i_op(iss_op), .i_tag(iss_tag),
    .i_qj_tag(qj_tag), .i_qj_wait(qj_wait), .i_vj(vj),
    .i_qk_tag(qk_tag), .i_qk_wait(qk_wait), .i_vk(vk),
    .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_value(cdb_value),
    .i_grant(alu_grant), .o_free(alu_free), .o_dispatch_valid(alu_disp_valid),
    .o_dispatch_op(alu_disp_op), .o_dispatch_a(alu_a), .o_dispatch_b(alu_b),
    .o_dispatch_tag(alu_disp_tag)
  );

  // every entry here is a mul, so the op is not needed downstream
  reservation_station rs_mul (
    .clk_100mhz, .sys_rst, .i_load(rs_mul_load), .i_op(iss_op), .i_tag(iss_tag),
    .i_qj_tag(qj_tag), .i_qj_wait(qj_wait), .i_vj(vj),
    .i_qk_tag(qk_tag), .i_qk_wait(qk_wait), .i_vk(vk),
    .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_value(cdb_value),
    .i_grant(mul_grant), .o_free(mul_free), .o_dispatch_valid(mul_disp_valid),
    .o_dispatch_op(), .o_dispatch_a(mul_a), .o_dispatch_b(mul_b),
    .o_dispatch_tag(mul_disp_tag)
  );

  exec_cluster u_exec (
    .clk_100mhz, .sys_rst,
    .i_alu_valid(alu_disp_valid), .i_alu_op(alu_disp_op), .i_alu_a(alu_a),
    .i_alu_b(alu_b), .i_alu_tag(alu_disp_tag),
    .i_mul_valid(mul_disp_valid), .i_mul_a(mul_a), .i_mul_b(mul_b),
    .i_mul_tag(mul_disp_tag),
    .o_alu_grant(alu_grant), .o_mul_grant(mul_grant),
    .o_cdb_valid(cdb_valid), .o_cdb_tag(cdb_tag), .o_cdb_value(cdb_value)
  );

  reorder_buffer u_rob (
    .clk_100mhz, .sys_rst, .i_alloc(rob_alloc), .i_alloc_rd(alloc_rd),
    .i_fwd1_tag(fwd1_tag), .i_fwd2_tag(fwd2_tag),
    .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_value(cdb_value),
    .o_alloc_tag(alloc_tag), .o_full(rob_full),
    .o_fwd1_ready(fwd1_ready), .o_fwd1_value(fwd1_value),
    .o_fwd2_ready(fwd2_ready), .o_fwd2_value(fwd2_value),
    .o_commit_valid, .o_commit_rd, .o_commit_value, .o_commit_tag(commit_tag)
  );

endmodule

`default_nettype wire

//--- tb/ooo_core_props.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_props import isa_pkg::*; (
  input wire clk_100mhz,
  input wire sys_rst,
  input wire i_inst_valid,
  input wire o_credit,
  input wire o_commit_valid,
  input wire word_t o_commit_value
);
  int unsigned sent_cnt;
  int unsigned returned_cnt;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      sent_cnt <= 0;
      returned_cnt <= 0;
    end else begin
      if (i_inst_valid) sent_cnt <= sent_cnt + 1;
      if (o_credit) returned_cnt <= returned_cnt + 1;
    end
  end

  // both outputs quiet in the first cycle out of reset
  assert property (@(posedge clk_100mhz) $fell(sys_rst) |-> !o_credit && !o_commit_valid)
  else $error("credit or commit active in the first cycle after reset");

  // a credit only comes back for an instruction still held
  assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_credit |-> returned_cnt < sent_cnt)
  else $error("more credits returned than instructions sent");

  assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_commit_valid |-> !$isunknown(o_commit_value))
  else $error("commit value unknown while commit is valid");

endmodule

`default_nettype wire

//--- tb/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core import isa_pkg::*, core_pkg::*; ();
  localparam int WAIT_LIMIT = 2000; // cycles per wait loop

  logic clk_100mhz;
  logic sys_rst;
  logic i_inst_valid;
  inst_t i_inst;
  logic o_credit;
  logic o_commit_valid;
  reg_ix_t o_commit_rd;
  word_t o_commit_value;

  // golden model state and expected commit stream
  word_t gold_regs [32];
  reg_ix_t exp_rd [1024];
  word_t exp_val [1024];
  logic [9:0] exp_wr;
  logic [9:0] commit_ix;
  reg_ix_t exp_rd_now;
  word_t exp_val_now;
  int sent_cnt;
  int credit_cnt;
  int rd_err = 0;
  int val_err = 0;
  int extra_err = 0;
  int reset_err = 0;
  int timeout_err = 0;
  int tests_run = 0;
  int tests_ok = 0;
  int err_mark = 0;
  logic aborted;

  ooo_core_top dut (
    .clk_100mhz, .sys_rst, .i_inst_valid, .i_inst,
    .o_credit, .o_commit_valid, .o_commit_rd, .o_commit_value
  );

  bind ooo_core_top ooo_core_props u_props (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .i_inst_valid(i_inst_valid),
    .o_credit(o_credit), .o_commit_valid(o_commit_valid), .o_commit_value(o_commit_value)
  );

  always #5 clk_100mhz = ~clk_100mhz;

  always @(posedge clk_100mhz) begin
    if (sys_rst) begin
      credit_cnt <= 0;
      commit_ix <= '0;
    end else begin
      if (o_credit) credit_cnt <= credit_cnt + 1;
      if (o_commit_valid) commit_ix <= commit_ix + 1'b1;
    end
  end

  assign exp_rd_now = exp_rd[commit_ix];
  assign exp_val_now = exp_val[commit_ix];

  // a commit must have a golden result waiting for it
  assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_commit_valid |-> commit_ix < exp_wr)
  else begin
    $display("commit to x%0d arrived with no instruction outstanding",
             $sampled(o_commit_rd));
    extra_err++;
  end

  assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (o_commit_valid && commit_ix < exp_wr) |-> o_commit_rd == exp_rd_now)
  else begin
    $display("[FAIL] o_commit_rd got %h expected %h",
             $sampled(o_commit_rd), $sampled(exp_rd_now));
    rd_err++;
  end

  assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    (o_commit_valid && commit_ix < exp_wr) |-> o_commit_value == exp_val_now)
  else begin
    $display("[FAIL] o_commit_value got %h expected %h",
             $sampled(o_commit_value), $sampled(exp_val_now));
    val_err++;
  end

  assert property (@(posedge clk_100mhz) $fell(sys_rst) |-> !o_credit && !o_commit_valid)
  else begin
    $display("credit or commit was active in the first cycle after reset");
    reset_err++;
  end

  function automatic int total_errors();
    return rd_err + val_err + extra_err + reset_err + timeout_err;
  endfunction

  function automatic inst_t enc_r(input logic [6:0] f7, input reg_ix_t rs2, input reg_ix_t rs1,
                                  input logic [2:0] f3, input reg_ix_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic inst_t enc_i(input logic [11:0] imm, input reg_ix_t rs1,
                                  input logic [2:0] f3, input reg_ix_t rd);
    return {imm, rs1, f3, rd, OPC_OPIMM};
  endfunction

  function automatic inst_t enc_u(input logic [19:0] imm, input reg_ix_t rd);
    return {imm, rd, OPC_LUI};
  endfunction

  // executes one instruction in program order, queues its commit
  task automatic model_inst(input inst_t inst);
    word_t a, b, res;
    logic [6:0] f7;
    logic [2:0] f3;
    reg_ix_t rd;
    logic ok;
    ok = 1'b1;
    res = '0;
    f7 = inst[31:25];
    f3 = inst[14:12];
    rd = inst[11:7];
    a = gold_regs[inst[19:15]];
    b = (inst[6:0] == OPC_OPIMM) ? {{20{inst[31]}}, inst[31:20]} : gold_regs[inst[24:20]];
    if (inst[6:0] == OPC_LUI) begin
      res = {inst[31:12], 12'h000};
    end else if (inst[6:0] == OPC_OP && f7 == F7_MULDIV) begin
      ok = (f3 == 3'b000); // mul only, the rest of the m extension is dropped
      res = a * b;
    end else if (inst[6:0] == OPC_OP || inst[6:0] == OPC_OPIMM) begin
      case (f3)
        3'd0: res = (inst[6:0] == OPC_OP && f7 == F7_ALT) ? a - b : a + b;
        3'd1: res = a << b[4:0];
        3'd2: res = {31'b0, $signed(a) < $signed(b)};
        3'd3: res = {31'b0, a < b};
        3'd4: res = a ^ b;
        3'd5: begin
          if (f7 == F7_ALT) res = $signed(a) >>> b[4:0];
          else res = a >> b[4:0];
        end
        3'd6: res = a | b;
        default: res = a & b;
      endcase
    end else begin
      ok = 1'b0; // branch, load and the rest
    end
    if (ok) begin
      exp_rd[exp_wr] = rd;
      exp_val[exp_wr] = res;
      exp_wr = exp_wr + 1'b1;
      if (rd != 5'd0) gold_regs[rd] = res;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s", what);
    timeout_err++;
    aborted = 1'b1;
  endtask

  task automatic send_inst(input inst_t inst);
    int waited;
    waited = 0;
    if (!aborted) begin
      @(posedge clk_100mhz);
      while (sent_cnt - credit_cnt >= IQ_CREDITS && waited < WAIT_LIMIT) begin
        i_inst_valid <= 1'b0; // out of credit
        @(posedge clk_100mhz);
        waited++;
      end
      if (sent_cnt - credit_cnt >= IQ_CREDITS) begin
        report_timeout("no credit came back while sending");
      end else begin
        i_inst_valid <= 1'b1;
        i_inst <= inst;
        sent_cnt++;
        model_inst(inst);
      end
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk_100mhz);
      i_inst_valid <= 1'b0;
    end
  endtask

  // wait for every commit and every credit
  task automatic drain();
    int waited;
    waited = 0;
    if (!aborted) begin
      @(posedge clk_100mhz);
      i_inst_valid <= 1'b0;
      while ((commit_ix != exp_wr || credit_cnt != sent_cnt) && waited < WAIT_LIMIT) begin
        @(posedge clk_100mhz);
        waited++;
      end
      if (commit_ix != exp_wr || credit_cnt != sent_cnt) begin
        report_timeout("results or credits still outstanding");
      end
    end
  endtask

  task automatic finish_test(input string name);
    int now_err;
    now_err = total_errors();
    tests_run++;
    if (now_err == err_mark) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d error(s)", name, now_err - err_mark);
    end
    err_mark = now_err;
  endtask

  function automatic inst_t rand_inst();
    int kind;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm;
    reg_ix_t rd, rs1, rs2;
    kind = $urandom_range(0, 9);
    f3 = 3'($urandom_range(0, 7));
    rd = 5'($urandom_range(0, 7)); // few registers for many dependencies
    rs1 = 5'($urandom_range(0, 7));
    rs2 = 5'($urandom_range(0, 7));
    imm = 12'($urandom);
    if (kind < 4) begin
      f7 = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? F7_ALT : F7_BASE;
      return enc_r(f7, rs2, rs1, f3, rd);
    end else if (kind < 6) begin
      return enc_r(F7_MULDIV, rs2, rs1, 3'b000, rd);
    end else if (kind < 9) begin
      if (f3 == 3'd1) imm = {F7_BASE, imm[4:0]};
      if (f3 == 3'd5) imm = {($urandom_range(0, 1) == 1) ? F7_ALT : F7_BASE, imm[4:0]};
      return enc_i(imm, rs1, f3, rd);
    end
    return enc_u(20'($urandom), rd);
  endfunction

  initial begin
    clk_100mhz = 1'b0;
    sys_rst = 1'b1;
    i_inst_valid = 1'b0;
    i_inst = '0;
    exp_wr = '0;
    sent_cnt = 0;
    aborted = 1'b0;
    for (int r = 0; r < 32; r++) gold_regs[r] = '0;
    void'($urandom(32'ha030));
    repeat (2) @(posedge clk_100mhz);
    sys_rst <= 1'b0;

    // full credit burst straight out of reset
    send_inst(enc_i(12'd5, 5'd0, 3'd0, 5'd1));
    send_inst(enc_i(12'hffd, 5'd0, 3'd0, 5'd2));
    send_inst(enc_u(20'h12345, 5'd3));
    send_inst(enc_i(12'h7ff, 5'd0, 3'd0, 5'd4));
    drain();
    finish_test("reset_burst");

    for (int f = 0; f < 8; f++) send_inst(enc_r(F7_BASE, 5'd2, 5'd1, 3'(f), 5'(8 + f)));
    send_inst(enc_r(F7_ALT, 5'd2, 5'd1, 3'd0, 5'd16)); // sub
    send_inst(enc_r(F7_ALT, 5'd1, 5'd2, 3'd5, 5'd17)); // sra
    for (int f = 0; f < 8; f++) begin
      if (f != 1 && f != 5) send_inst(enc_i(12'hf85, 5'd1, 3'(f), 5'(18 + f)));
    end
    send_inst(enc_i({F7_BASE, 5'd4}, 5'd3, 3'd1, 5'd26));
    send_inst(enc_i({F7_BASE, 5'd7}, 5'd2, 3'd5, 5'd27));
    send_inst(enc_i({F7_ALT, 5'd7}, 5'd2, 3'd5, 5'd28));
    send_inst(enc_u(20'habcde, 5'd29));
    drain();
    finish_test("independent_ops");

    send_inst(enc_r(F7_MULDIV, 5'd2, 5'd1, 3'd0, 5'd5));
    send_inst(enc_r(F7_BASE, 5'd1, 5'd5, 3'd0, 5'd6)); // waits on the product
    repeat (4) send_inst(enc_i(12'd1, 5'd7, 3'd0, 5'd7));
    send_inst(enc_r(F7_MULDIV, 5'd6, 5'd6, 3'd0, 5'd8));
    send_inst(enc_r(F7_ALT, 5'd5, 5'd8, 3'd0, 5'd9));
    send_inst(enc_r(F7_MULDIV, 5'd9, 5'd8, 3'd0, 5'd10));
    send_inst(enc_i(12'hfff, 5'd10, 3'd0, 5'd11));
    drain();
    finish_test("dependency_chains");

    send_inst(enc_i(12'd9, 5'd1, 3'd0, 5'd0));
    send_inst(enc_r(F7_BASE, 5'd1, 5'd0, 3'd0, 5'd12));
    send_inst(enc_u(20'h55555, 5'd0));
    send_inst(enc_r(F7_BASE, 5'd0, 5'd0, 3'd6, 5'd13));
    send_inst(enc_i(12'd3, 5'd0, 3'd0, 5'd14));
    drain();
    finish_test("x0_handling");

    send_inst(enc_i(12'd21, 5'd0, 3'd0, 5'd15));
    send_inst(32'h00208463); // beq
    send_inst(32'h0000a183); // lw
    send_inst(enc_r(F7_MULDIV, 5'd2, 5'd1, 3'd4, 5'd16)); // div
    send_inst(enc_i(12'd1, 5'd15, 3'd0, 5'd16));
    drain();
    finish_test("unsupported");

    for (int n = 0; n < 200; n++) begin
      send_inst(rand_inst());
      idle(int'($urandom_range(0, 3)));
    end
    drain();
    finish_test("random_stream");

    $display("tests run %0d, ok %0d, commits %0d, errors %0d",
             tests_run, tests_ok, commit_ix, total_errors());
    if (total_errors() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
src/isa_pkg.sv
src/core_pkg.sv
src/inst_queue_decode.sv
src/rename_issue.sv
src/reservation_station.sv
src/exec_cluster.sv
src/reorder_buffer.sv
src/ooo_core_top.sv
tb/ooo_core_props.sv
tb/tb_ooo_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the out-of-order core testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_ooo_core

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ooo_core -f all.f --Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
